/* Makefile */
# Verilator build and run for the mailbox subsystem

VERILATOR ?= verilator
TOP       ?= mbox_top_tb
RTL_TOP   ?= mbox_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status follows the search for the pass message
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
design/mbox_pkg.sv
design/mbox_soc_ifc.sv
design/mbox_sram.sv
design/mbox_dma.sv
design/ext_bus_decode.sv
design/ext_sram.sv
design/mbox_top.sv
tests/mbox_checker.sv
tests/mbox_top_tb.sv

/* design/ext_bus_decode.sv */
// External address decoder for the DMA bus
// Registered hop to the scratch SRAM, decode error for unmapped addresses
`timescale 1ns/1ps

module ext_bus_decode (
    input  logic                        core_clk,
    input  logic                        arst_n,
    input  logic                        bus_req,
    input  logic                        bus_we,
    input  logic [mbox_pkg::dma_aw-1:0] bus_addr,
    input  logic [mbox_pkg::data_w-1:0] bus_wdata,
    output logic                        bus_ack,
    output logic [mbox_pkg::data_w-1:0] bus_rdata,
    output logic                        bus_err,
    output logic                        sram_req,
    output logic                        sram_we,
    output logic [mbox_pkg::ext_aw-1:0] sram_idx,
    output logic [mbox_pkg::data_w-1:0] sram_wdata,
    input  logic                        sram_ack,
    input  logic [mbox_pkg::data_w-1:0] sram_rdata
);

    logic hit;
    logic err_ack;

    assign hit = (bus_addr[mbox_pkg::dma_aw-1 -: 8] == mbox_pkg::ext_base_hi);

    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            sram_req <= 1'b0;
            err_ack  <= 1'b0;
        end else begin
            sram_req <= bus_req && hit;
            // Unmapped requests are answered here
            err_ack  <= bus_req && !hit;
        end
    end

    always_ff @(posedge core_clk) begin
        sram_we    <= bus_we;
        sram_idx   <= bus_addr[mbox_pkg::ext_aw-1:0];
        sram_wdata <= bus_wdata;
    end

    assign bus_ack   = sram_ack || err_ack;
    assign bus_err   = err_ack;
    assign bus_rdata = err_ack ? '0 : sram_rdata;

endmodule

/* design/ext_sram.sv */
// Scratch SRAM, 256 words behind a four-phase responder
`timescale 1ns/1ps

module ext_sram (
    input  logic                        core_clk,
    input  logic                        arst_n,
    input  logic                        sram_req,
    input  logic                        sram_we,
    input  logic [mbox_pkg::ext_aw-1:0] sram_idx,
    input  logic [mbox_pkg::data_w-1:0] sram_wdata,
    output logic                        sram_ack,
    output logic [mbox_pkg::data_w-1:0] sram_rdata
);

    logic [mbox_pkg::data_w-1:0] mem [mbox_pkg::ext_depth];

    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            sram_ack   <= 1'b0;
            sram_rdata <= '0;
            for (int i = 0; i < mbox_pkg::ext_depth; i++) begin
                mem[i] <= '0;
            end
        end else begin
            sram_ack <= sram_req;
            // Access once, on the first cycle of a request
            if (sram_req && !sram_ack) begin
                if (sram_we)
                    mem[sram_idx] <= sram_wdata;
                sram_rdata <= mem[sram_idx];
            end
        end
    end

endmodule

/* design/mbox_dma.sv */
// DMA sequencer between mailbox and external bus
// One mailbox cycle and one four-phase bus transfer per word
`timescale 1ns/1ps

module mbox_dma (
    input  logic                         core_clk,
    input  logic                         arst_n,
    input  logic                         dma_start,
    input  mbox_pkg::dma_dir_e           dma_dir,
    input  logic [mbox_pkg::mbox_aw:0]   dma_len,
    input  logic [mbox_pkg::dma_aw-1:0]  dma_base,
    output logic                         dma_busy,
    output logic                         dma_fin,
    output logic                         dma_err,
    output logic                         dma_mem_en,
    output logic                         dma_mem_we,
    output logic [mbox_pkg::mbox_aw-1:0] dma_mem_idx,
    output logic [mbox_pkg::data_w-1:0]  dma_mem_wdata,
    input  logic [mbox_pkg::data_w-1:0]  mem_rdata,
    output logic                         bus_req,
    output logic                         bus_we,
    output logic [mbox_pkg::dma_aw-1:0]  bus_addr,
    output logic [mbox_pkg::data_w-1:0]  bus_wdata,
    input  logic                         bus_ack,
    input  logic [mbox_pkg::data_w-1:0]  bus_rdata,
    input  logic                         bus_err
);

    mbox_pkg::dma_state_e       state;
    logic [mbox_pkg::mbox_aw:0] idx;
    logic [mbox_pkg::mbox_aw:0] idx_next;
    logic                       err_q;
    logic                       to_ext;

    assign to_ext   = (dma_dir == mbox_pkg::dir_to_ext);
    assign idx_next = idx + 1'b1;

    assign dma_busy = (state != mbox_pkg::idle);
    assign dma_fin  = (state == mbox_pkg::done);
    assign dma_err  = err_q;

    // Read ahead for outbound words, write back on a clean inbound ack
    assign dma_mem_en = (state == mbox_pkg::req_mbox && to_ext) ||
                        (state == mbox_pkg::wait_ack && bus_ack && !bus_err && !to_ext);
    assign dma_mem_we    = !to_ext;
    assign dma_mem_idx   = idx[mbox_pkg::mbox_aw-1:0];
    assign dma_mem_wdata = bus_rdata;

    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= mbox_pkg::idle;
            idx       <= '0;
            err_q     <= 1'b0;
            bus_req   <= 1'b0;
            bus_we    <= 1'b0;
            bus_addr  <= '0;
            bus_wdata <= '0;
        end else begin
            case (state)
                mbox_pkg::idle:
                    if (dma_start) begin
                        idx   <= '0;
                        err_q <= 1'b0;
                        state <= (dma_len == '0) ? mbox_pkg::done : mbox_pkg::req_mbox;
                    end
                mbox_pkg::req_mbox: state <= mbox_pkg::req_bus;
                mbox_pkg::req_bus: begin
                    bus_req   <= 1'b1;
                    bus_we    <= to_ext;
                    bus_addr  <= dma_base +
                                 {{(mbox_pkg::dma_aw - mbox_pkg::mbox_aw - 1){1'b0}}, idx};
                    bus_wdata <= mem_rdata;
                    state     <= mbox_pkg::wait_ack;
                end
                mbox_pkg::wait_ack:
                    if (bus_ack) begin
                        bus_req <= 1'b0;
                        err_q   <= bus_err;
                        state   <= mbox_pkg::wait_release;
                    end
                mbox_pkg::wait_release:
                    if (!bus_ack) begin
                        // Stop at the first errored word
                        if (err_q || idx_next == dma_len) begin
                            state <= mbox_pkg::done;
                        end else begin
                            idx   <= idx_next;
                            state <= mbox_pkg::req_mbox;
                        end
                    end
                mbox_pkg::done: state <= mbox_pkg::idle;
                default: state <= mbox_pkg::idle;
            endcase
        end
    end

    // Request and its fields hold until the responder acks
    a_req_held: assert property (@(posedge core_clk) disable iff (!arst_n)
        (bus_req && !bus_ack) |=> (bus_req && $stable(bus_addr) && $stable(bus_we)));

endmodule

/* design/mbox_pkg.sv */
// Mailbox subsystem shared definitions
// Sizes, register offsets, DMA direction and state enums, status bits
package mbox_pkg;

    // Mailbox and scratch SRAM geometry
    localparam int mbox_depth = 64;
    localparam int mbox_aw    = 6;
    localparam int ext_depth  = 256;
    localparam int ext_aw     = 8;

    // External word address, upper byte picks the target
    localparam int         dma_aw      = 16;
    localparam logic [7:0] ext_base_hi = 8'h40;

    localparam int data_w = 32;
    localparam int reg_aw = 4;

    typedef enum logic [reg_aw-1:0] {
        reg_lock     = 4'd0,
        reg_unlock   = 4'd1,
        reg_dlen     = 4'd2,
        reg_datain   = 4'd3,
        reg_dataout  = 4'd4,
        reg_dma_addr = 4'd5,
        reg_dma_cmd  = 4'd6,
        reg_status   = 4'd7
    } reg_e;

    typedef enum logic {
        dir_to_ext   = 1'b0,
        dir_from_ext = 1'b1
    } dma_dir_e;

    typedef enum logic [2:0] {
        idle,
        req_mbox,
        req_bus,
        wait_ack,
        wait_release,
        done
    } dma_state_e;

    // Status word bit positions
    localparam int stat_busy = 0;
    localparam int stat_done = 1;
    localparam int stat_err  = 2;

endpackage

/* design/mbox_soc_ifc.sv */
// SoC register port of the mailbox
// Four-phase handshake FSM, lock, push/pop pointers, DMA setup and status
`timescale 1ns/1ps

module mbox_soc_ifc (
    input  logic                         core_clk,
    input  logic                         arst_n,
    input  logic                         soc_req,
    input  logic                         soc_we,
    input  logic [mbox_pkg::reg_aw-1:0]  soc_addr,
    input  logic [mbox_pkg::data_w-1:0]  soc_wdata,
    output logic                         soc_ack,
    output logic [mbox_pkg::data_w-1:0]  soc_rdata,
    output logic                         ifc_mem_en,
    output logic                         ifc_mem_we,
    output logic [mbox_pkg::mbox_aw-1:0] ifc_mem_idx,
    output logic [mbox_pkg::data_w-1:0]  ifc_mem_wdata,
    input  logic [mbox_pkg::data_w-1:0]  mem_rdata,
    output logic                         dma_start,
    output mbox_pkg::dma_dir_e           dma_dir,
    output logic [mbox_pkg::mbox_aw:0]   dma_len,
    output logic [mbox_pkg::dma_aw-1:0]  dma_base,
    input  logic                         dma_busy,
    input  logic                         dma_fin,
    input  logic                         dma_err
);

    typedef enum logic [2:0] {
        hs_idle,
        hs_mem,
        hs_resp,
        hs_hold,
        hs_drop
    } hs_state_e;

    hs_state_e                    hs_state;
    mbox_pkg::reg_e               reg_sel;
    logic                         lock;
    logic                         mem_hit;
    logic                         done_q;
    logic                         err_q;
    logic [mbox_pkg::mbox_aw-1:0] wr_ptr;
    logic [mbox_pkg::mbox_aw-1:0] rd_ptr;
    logic [mbox_pkg::data_w-1:0]  rd_word;

    assign reg_sel = mbox_pkg::reg_e'(soc_addr);

    // Push/pop access goes out one cycle before the response
    assign ifc_mem_en = (hs_state == hs_mem) && !dma_busy &&
                        ((soc_we && lock && reg_sel == mbox_pkg::reg_datain) ||
                         (!soc_we && reg_sel == mbox_pkg::reg_dataout));
    assign ifc_mem_we    = soc_we;
    assign ifc_mem_idx   = soc_we ? wr_ptr : rd_ptr;
    assign ifc_mem_wdata = soc_wdata;

    // Read mux
    always_comb begin
        rd_word = '0;
        case (reg_sel)
            mbox_pkg::reg_lock:     rd_word[0] = lock;
            mbox_pkg::reg_dlen:     rd_word[mbox_pkg::mbox_aw:0] = dma_len;
            mbox_pkg::reg_datain:   rd_word[mbox_pkg::mbox_aw-1:0] = dma_busy ? '0 : wr_ptr;
            mbox_pkg::reg_dataout:  rd_word = mem_hit ? mem_rdata : '0;
            mbox_pkg::reg_dma_addr: rd_word[mbox_pkg::dma_aw-1:0] = dma_base;
            mbox_pkg::reg_dma_cmd:  rd_word[1] = dma_dir;
            mbox_pkg::reg_status: begin
                rd_word[mbox_pkg::stat_busy] = dma_busy;
                rd_word[mbox_pkg::stat_done] = done_q;
                rd_word[mbox_pkg::stat_err]  = err_q;
            end
            default: rd_word = '0;
        endcase
    end

    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            hs_state  <= hs_idle;
            soc_ack   <= 1'b0;
            soc_rdata <= '0;
            lock      <= 1'b0;
            mem_hit   <= 1'b0;
            done_q    <= 1'b0;
            err_q     <= 1'b0;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            dma_start <= 1'b0;
            dma_dir   <= mbox_pkg::dir_to_ext;
            dma_len   <= '0;
            dma_base  <= '0;
        end else begin
            dma_start <= 1'b0;
            mem_hit   <= ifc_mem_en;
            case (hs_state)
                hs_idle: if (soc_req) hs_state <= hs_mem;
                hs_mem:  hs_state <= hs_resp;
                hs_resp: begin
                    hs_state  <= hs_hold;
                    soc_ack   <= 1'b1;
                    soc_rdata <= soc_we ? '0 : rd_word;
                    if (!soc_we && reg_sel == mbox_pkg::reg_lock)
                        lock <= 1'b1;
                    // Pointers only move when the mailbox access really happened
                    if (mem_hit) begin
                        if (soc_we)
                            wr_ptr <= wr_ptr + 1'b1;
                        else
                            rd_ptr <= rd_ptr + 1'b1;
                    end
                    if (soc_we && lock) begin
                        case (reg_sel)
                            mbox_pkg::reg_unlock: begin
                                lock   <= 1'b0;
                                wr_ptr <= '0;
                                rd_ptr <= '0;
                                done_q <= 1'b0;
                                err_q  <= 1'b0;
                            end
                            mbox_pkg::reg_dlen:
                                if (!dma_busy) dma_len <= soc_wdata[mbox_pkg::mbox_aw:0];
                            mbox_pkg::reg_dma_addr:
                                if (!dma_busy) dma_base <= soc_wdata[mbox_pkg::dma_aw-1:0];
                            mbox_pkg::reg_dma_cmd:
                                if (soc_wdata[0] && !dma_busy) begin
                                    dma_start <= 1'b1;
                                    dma_dir   <= mbox_pkg::dma_dir_e'(soc_wdata[1]);
                                    done_q    <= 1'b0;
                                    err_q     <= 1'b0;
                                end
                            default: ;
                        endcase
                    end
                end
                hs_hold: if (!soc_req) hs_state <= hs_drop;
                hs_drop: begin
                    soc_ack  <= 1'b0;
                    hs_state <= hs_idle;
                end
                default: hs_state <= hs_idle;
            endcase
            // DMA completion is sticky until unlock or the next start
            if (dma_fin) begin
                done_q <= 1'b1;
                err_q  <= dma_err;
            end
        end
    end

    // Req is looked at on the edge that raises ack, the agent may drop it right after
    a_ack_needs_req: assert property (@(posedge core_clk) disable iff (!arst_n)
        $rose(soc_ack) |-> $past(soc_req));

endmodule

/* design/mbox_sram.sv */
// Mailbox storage, 64 words with registered read
// Port select between SoC side and DMA by dma_busy
`timescale 1ns/1ps

module mbox_sram (
    input  logic                         core_clk,
    input  logic                         dma_busy,
    input  logic                         ifc_mem_en,
    input  logic                         ifc_mem_we,
    input  logic [mbox_pkg::mbox_aw-1:0] ifc_mem_idx,
    input  logic [mbox_pkg::data_w-1:0]  ifc_mem_wdata,
    input  logic                         dma_mem_en,
    input  logic                         dma_mem_we,
    input  logic [mbox_pkg::mbox_aw-1:0] dma_mem_idx,
    input  logic [mbox_pkg::data_w-1:0]  dma_mem_wdata,
    output logic [mbox_pkg::data_w-1:0]  mem_rdata
);

    logic [mbox_pkg::data_w-1:0]  mem [mbox_pkg::mbox_depth];
    logic                         sel_en;
    logic                         sel_we;
    logic [mbox_pkg::mbox_aw-1:0] sel_idx;
    logic [mbox_pkg::data_w-1:0]  sel_wdata;

    // DMA owns the array for the whole transfer
    assign sel_en    = dma_busy ? dma_mem_en    : ifc_mem_en;
    assign sel_we    = dma_busy ? dma_mem_we    : ifc_mem_we;
    assign sel_idx   = dma_busy ? dma_mem_idx   : ifc_mem_idx;
    assign sel_wdata = dma_busy ? dma_mem_wdata : ifc_mem_wdata;

    always_ff @(posedge core_clk) begin
        if (sel_en) begin
            if (sel_we)
                mem[sel_idx] <= sel_wdata;
            else
                mem_rdata <= mem[sel_idx];
        end
    end

    a_no_soc_during_dma: assert property (@(posedge core_clk)
        dma_busy |-> !ifc_mem_en);

endmodule

/* design/mbox_top.sv */
// Mailbox subsystem top
// SoC port, mailbox SRAM, DMA, address decoder and scratch SRAM
`timescale 1ns/1ps

module mbox_top (
    input  logic                        core_clk,
    input  logic                        arst_n,
    input  logic                        soc_req,
    input  logic                        soc_we,
    input  logic [mbox_pkg::reg_aw-1:0] soc_addr,
    input  logic [mbox_pkg::data_w-1:0] soc_wdata,
    output logic                        soc_ack,
    output logic [mbox_pkg::data_w-1:0] soc_rdata
);

    // SoC side of the mailbox
    logic                         ifc_mem_en;
    logic                         ifc_mem_we;
    logic [mbox_pkg::mbox_aw-1:0] ifc_mem_idx;
    logic [mbox_pkg::data_w-1:0]  ifc_mem_wdata;
    logic [mbox_pkg::data_w-1:0]  mem_rdata;

    // DMA control
    logic                         dma_start;
    mbox_pkg::dma_dir_e           dma_dir;
    logic [mbox_pkg::mbox_aw:0]   dma_len;
    logic [mbox_pkg::dma_aw-1:0]  dma_base;
    logic                         dma_busy;
    logic                         dma_fin;
    logic                         dma_err;

    // DMA side of the mailbox
    logic                         dma_mem_en;
    logic                         dma_mem_we;
    logic [mbox_pkg::mbox_aw-1:0] dma_mem_idx;
    logic [mbox_pkg::data_w-1:0]  dma_mem_wdata;

    // External bus and scratch SRAM port
    logic                         bus_req;
    logic                         bus_we;
    logic [mbox_pkg::dma_aw-1:0]  bus_addr;
    logic [mbox_pkg::data_w-1:0]  bus_wdata;
    logic                         bus_ack;
    logic [mbox_pkg::data_w-1:0]  bus_rdata;
    logic                         bus_err;
    logic                         sram_req;
    logic                         sram_we;
    logic [mbox_pkg::ext_aw-1:0]  sram_idx;
    logic [mbox_pkg::data_w-1:0]  sram_wdata;
    logic                         sram_ack;
    logic [mbox_pkg::data_w-1:0]  sram_rdata;

    mbox_soc_ifc u_soc_ifc (.*);

    mbox_sram u_mbox_sram (.*);

    mbox_dma u_dma (.*);

    ext_bus_decode u_decode (.*);

    ext_sram u_ext_sram (.*);

endmodule

/* tests/mbox_checker.sv */
// Response checker for the SoC register port
// Read data compare against trace expectations, four-phase rule checks
`timescale 1ns/1ps

module mbox_checker (
    input  logic                        core_clk,
    input  logic                        arst_n,
    input  logic                        soc_req,
    input  logic                        soc_ack,
    input  logic [mbox_pkg::data_w-1:0] soc_rdata,
    input  logic                        exp_valid,
    input  logic [mbox_pkg::data_w-1:0] exp_data,
    output int                          mismatch_cnt,
    output int                          proto_cnt
);

    logic                        ack_q;
    logic                        req_q;
    logic                        pending;
    logic [mbox_pkg::data_w-1:0] exp_q;

    always @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            ack_q        <= 1'b0;
            req_q        <= 1'b0;
            pending      <= 1'b0;
            exp_q        <= '0;
            mismatch_cnt <= 0;
            proto_cnt    <= 0;
        end else begin
            ack_q <= soc_ack;
            req_q <= soc_req;
            if (exp_valid) begin
                pending <= 1'b1;
                exp_q   <= exp_data;
            end
            // Ack seen high for the first time, rdata settled one edge ago
            if (soc_ack && !ack_q) begin
                if (!req_q) begin
                    $display("Handshake error: soc_ack rose without soc_req at %0t", $time);
                    proto_cnt <= proto_cnt + 1;
                end
                if (pending) begin
                    pending <= 1'b0;
                    if (soc_rdata !== exp_q) begin
                        $display("MISMATCH soc_rdata: got %08h, expected %08h",
                                 soc_rdata, exp_q);
                        mismatch_cnt <= mismatch_cnt + 1;
                    end
                end
            end
            if (!soc_ack && ack_q && req_q) begin
                $display("Handshake error: soc_ack fell while soc_req was high at %0t", $time);
                proto_cnt <= proto_cnt + 1;
            end
        end
    end

endmodule

/* tests/mbox_top_tb.sv */
// Mailbox subsystem testbench top
// Clock, reset, trace-driven SoC master, DUT and checker instances
`timescale 1ns/1ps

module mbox_top_tb;

    logic                        core_clk;
    logic                        arst_n;
    logic                        soc_req;
    logic                        soc_we;
    logic [mbox_pkg::reg_aw-1:0] soc_addr;
    logic [mbox_pkg::data_w-1:0] soc_wdata;
    logic                        soc_ack;
    logic [mbox_pkg::data_w-1:0] soc_rdata;
    logic                        exp_valid;
    logic [mbox_pkg::data_w-1:0] exp_data;
    int                          mismatch_cnt;
    int                          proto_cnt;
    int                          run_err_cnt;
    int                          fd;
    bit                          aborted;
    logic [7:0]                  op;
    logic [31:0]                 off;
    logic [31:0]                 val;
    logic [31:0]                 rd_val;
    string                       rest;

    mbox_top uut (.*);

    mbox_checker u_checker (.*);

    initial begin
        core_clk = 1'b0;
        forever #20 core_clk = ~core_clk;
    end

    // Flags a wait that ran out and stops the trace
    task automatic report_timeout(input string what);
        $display("Timeout: %s", what);
        run_err_cnt++;
        aborted = 1'b1;
    endtask

    // One four-phase transfer, entered 2 ns after a rising edge
    task automatic soc_access(input logic we, input logic [mbox_pkg::reg_aw-1:0] addr,
                              input logic [31:0] value, input logic check,
                              output logic [31:0] rdata);
        int n;
        soc_we    = we;
        soc_addr  = addr;
        soc_wdata = we ? value : '0;
        exp_data  = value;
        exp_valid = check;
        soc_req   = 1'b1;
        @(posedge core_clk);
        #2;
        exp_valid = 1'b0;
        n = 0;
        while (!soc_ack && n < 100) begin
            @(posedge core_clk);
            #2;
            n++;
        end
        if (!soc_ack) begin
            report_timeout($sformatf("soc_ack never rose for offset %0h", addr));
        end
        rdata   = soc_rdata;
        soc_req = 1'b0;
        n = 0;
        while (soc_ack && n < 100) begin
            @(posedge core_clk);
            #2;
            n++;
        end
        if (soc_ack) begin
            report_timeout($sformatf("soc_ack never fell for offset %0h", addr));
        end
    endtask

    // Re-read until the masked bits read back as zero
    task automatic poll_clear(input logic [mbox_pkg::reg_aw-1:0] addr, input logic [31:0] mask);
        logic [31:0] r;
        int n;
        r = mask;
        n = 0;
        while ((r & mask) != 0 && n < 50 && !aborted) begin
            soc_access(1'b0, addr, 32'h0, 1'b0, r);
            n++;
        end
        if ((r & mask) != 0 && !aborted) begin
            report_timeout($sformatf("bits %08h of offset %0h never cleared", mask, addr));
        end
    endtask

    initial begin
        soc_req     = 1'b0;
        soc_we      = 1'b0;
        soc_addr    = '0;
        soc_wdata   = '0;
        exp_valid   = 1'b0;
        exp_data    = '0;
        run_err_cnt = 0;
        aborted     = 1'b0;
        arst_n      = 1'b0;
        repeat (3) @(posedge core_clk);
        #2;
        arst_n = 1'b1;
        @(posedge core_clk);
        #2;
        fd = $fopen("tests/mbox_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file tests/mbox_trace.txt");
            run_err_cnt++;
        end else begin
            while (!aborted && $fscanf(fd, " %c", op) == 1) begin
                if (op == "#") begin
                    void'($fgets(rest, fd));
                end else if ($fscanf(fd, " %h %h", off, val) != 2) begin
                    $display("Trace line starting with %c has no offset and value", op);
                    run_err_cnt++;
                    aborted = 1'b1;
                end else begin
                    case (op)
                        "W": soc_access(1'b1, off[mbox_pkg::reg_aw-1:0], val, 1'b0, rd_val);
                        "R": soc_access(1'b0, off[mbox_pkg::reg_aw-1:0], val, 1'b1, rd_val);
                        "P": poll_clear(off[mbox_pkg::reg_aw-1:0], val);
                        default: begin
                            $display("Unknown trace operation %c", op);
                            run_err_cnt++;
                        end
                    endcase
                end
            end
            $fclose(fd);
        end
        repeat (2) @(posedge core_clk);
        $display("Errors: %0d mismatch, %0d handshake, %0d other",
                 mismatch_cnt, proto_cnt, run_err_cnt);
        if (mismatch_cnt == 0 && proto_cnt == 0 && run_err_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* tests/mbox_trace.txt */
# op offset value, all hex. W writes value, R reads and expects value,
# P polls offset until (read data & value) == 0
# Lock and writes ignored without it
W 2 00000005
R 2 00000000
R 0 00000000
R 0 00000001
# Push and pop
W 3 cafe0001
W 3 12345678
W 3 deadbeef
W 3 a5a55a5a
R 4 cafe0001
R 4 12345678
R 4 deadbeef
R 4 a5a55a5a
# Out to scratch SRAM, clobber word 0, bring it back
W 2 00000004
W 5 00004010
W 6 00000001
P 7 00000001
R 7 00000002
W 1 00000000
R 0 00000000
W 3 00000bad
W 6 00000003
P 7 00000001
R 7 00000002
R 4 cafe0001
R 4 12345678
R 4 deadbeef
R 4 a5a55a5a
# Unmapped target
W 5 00002000
W 6 00000001
P 7 00000001
R 7 00000006
# Unlock clears status, pop while busy
W 1 00000000
R 7 00000000
R 0 00000000
W 5 00004010
W 6 00000001
R 4 00000000
P 7 00000001
R 7 00000002
R 4 cafe0001
